/* hw/tnn_pkg.sv */
package tnn_pkg;

  localparam int FEAT_CNT = 4;
  localparam int FEAT_BITS = 4;
  localparam int HIDDEN_CNT = 8;
  localparam int CLASS_CNT = 4;
  localparam int CLASS_BITS = $clog2(CLASS_CNT);
  localparam int HIDDEN_IDX_BITS = $clog2(HIDDEN_CNT);
  localparam int SUM_BITS = FEAT_BITS + $clog2(FEAT_CNT + 1); // room for all features at max

  // bit [n][f] set means feature f enters neuron n with weight +1 or -1
  localparam logic [HIDDEN_CNT-1:0][FEAT_CNT-1:0] POS_MASK = {
    4'b0011, 4'b1000, 4'b0101, 4'b0000, 4'b1100, 4'b0010, 4'b1001, 4'b0110
  };
  localparam logic [HIDDEN_CNT-1:0][FEAT_CNT-1:0] NEG_MASK = {
    4'b0100, 4'b0011, 4'b1010, 4'b0001, 4'b0011, 4'b1101, 4'b0110, 4'b1000
  };

  // class 1 has an empty compressed row
  localparam logic [CLASS_CNT:0][7:0] ROW_PTRS = {8'd14, 8'd9, 8'd4, 8'd4, 8'd0};
  localparam int NONZERO_TOTAL = int'(ROW_PTRS[CLASS_CNT]);
  localparam logic [NONZERO_TOTAL-1:0][7:0] COL_INDICES = {
    8'd7, 8'd5, 8'd3, 8'd1, 8'd0,
    8'd6, 8'd4, 8'd3, 8'd2, 8'd1,
    8'd7, 8'd5, 8'd2, 8'd0
  };
  localparam logic [NONZERO_TOTAL-1:0] NZ_VALS = 14'b10110_01101_1001;

  function automatic int row_maxlen();
    int m;
    m = 0;
    for (int c = 0; c < CLASS_CNT; c++) begin
      if (int'(ROW_PTRS[c+1]) - int'(ROW_PTRS[c]) > m) m = int'(ROW_PTRS[c+1]) - int'(ROW_PTRS[c]);
    end
    return m;
  endfunction

  localparam int MAXLEN = row_maxlen();
  localparam int SCORE_BITS = $clog2(MAXLEN + 1);
  localparam int STEP_BITS = $clog2(HIDDEN_CNT > NONZERO_TOTAL ? HIDDEN_CNT : NONZERO_TOTAL);

  typedef struct packed {
    logic [FEAT_CNT-1:0][FEAT_BITS-1:0] feat;
  } tnn_features_t;

  typedef logic [HIDDEN_CNT-1:0] tnn_hidden_t; // bit i is neuron i

  typedef struct packed {
    logic [CLASS_CNT-1:0][SCORE_BITS-1:0] score;
  } tnn_scores_t;

  typedef enum logic [1:0] {PH_IDLE, PH_LAYER1, PH_LAYER2, PH_DONE} tnn_phase_t;

endpackage

/* hw/tnn_ctrl.sv */
`timescale 1ns/100ps

module tnn_ctrl (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               start,
  input  logic               last,
  output tnn_pkg::tnn_phase_t phase,
  output logic               load,
  output logic               l1_step,
  output logic               l2_step,
  output logic               finish,
  output logic               done,
  output logic               busy
);

  import tnn_pkg::*;

  tnn_phase_t state;
  tnn_phase_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      PH_IDLE: begin
        if (start) state_nxt = PH_LAYER1;
      end
      PH_LAYER1: begin
        if (last) state_nxt = PH_LAYER2;
      end
      PH_LAYER2: begin
        if (last) state_nxt = PH_DONE;
      end
      default: state_nxt = PH_IDLE; // the done state lasts a single cycle
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= PH_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign phase = state;
  assign load = start && (state == PH_IDLE); // starts during a run are dropped here
  assign l1_step = (state == PH_LAYER1);
  assign l2_step = (state == PH_LAYER2);

  // scores are complete once layer two has left, so the argmax samples in the done state
  assign finish = (state == PH_DONE);
  assign busy = (state != PH_IDLE);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= finish; // lines up with the new prediction
    end
  end

endmodule

/* hw/tnn_step_counter.sv */
`timescale 1ns/100ps

module tnn_step_counter (
  input  logic                          clk,
  input  logic                          rst_n,
  input  tnn_pkg::tnn_phase_t           phase,
  output logic [tnn_pkg::STEP_BITS-1:0] step,
  output logic                          last
);

  import tnn_pkg::*;

  logic [STEP_BITS-1:0] limit;
  logic                 in_layer;

  always_comb begin
    case (phase)
      PH_LAYER1: limit = STEP_BITS'(HIDDEN_CNT - 1);
      PH_LAYER2: limit = STEP_BITS'(NONZERO_TOTAL - 1);
      default:   limit = '0;
    endcase
  end

  assign in_layer = (phase == PH_LAYER1) || (phase == PH_LAYER2);
  assign last = in_layer && (step == limit);

  // the phase only moves on last or out of a layer, so clearing there restarts every phase at 0
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      step <= '0;
    end else if (!in_layer || last) begin
      step <= '0;
    end else begin
      step <= step + 1'b1;
    end
  end

endmodule

/* hw/ternary_layer.sv */
`timescale 1ns/100ps

module ternary_layer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic                          l1_step,
  input  tnn_pkg::tnn_features_t        features,
  input  logic [tnn_pkg::STEP_BITS-1:0] step,
  output tnn_pkg::tnn_hidden_t          hidden
);

  import tnn_pkg::*;

  tnn_features_t             feat_q;
  logic [HIDDEN_IDX_BITS-1:0] neuron;
  logic [SUM_BITS-1:0]        pos_sum;
  logic [SUM_BITS-1:0]        neg_sum;

  always_ff @(posedge clk) begin
    if (load) begin
      feat_q <= features;
    end
  end

  assign neuron = step[HIDDEN_IDX_BITS-1:0];

  // weight +1 and weight -1 features are summed apart so no signed math is needed
  always_comb begin
    pos_sum = '0;
    neg_sum = '0;
    for (int f = 0; f < FEAT_CNT; f++) begin
      if (POS_MASK[neuron][f]) begin
        pos_sum = pos_sum + SUM_BITS'(feat_q.feat[f]);
      end
      if (NEG_MASK[neuron][f]) begin
        neg_sum = neg_sum + SUM_BITS'(feat_q.feat[f]);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hidden <= '0;
    end else if (l1_step) begin
      hidden[neuron] <= (pos_sum > neg_sum); // equal sums give 0
    end
  end

endmodule

/* hw/xnor_layer.sv */
`timescale 1ns/100ps

module xnor_layer (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load,
  input  logic                          l2_step,
  input  logic [tnn_pkg::STEP_BITS-1:0] step,
  input  tnn_pkg::tnn_hidden_t          hidden,
  output tnn_pkg::tnn_scores_t          scores
);

  import tnn_pkg::*;

  logic [CLASS_BITS-1:0]      cur_class;
  logic [CLASS_BITS-1:0]      row_class;
  logic [7:0]                 nz_idx;
  logic [HIDDEN_IDX_BITS-1:0] col;
  logic                       match;

  assign nz_idx = 8'(step);

  // move past every row whose end the walk has reached, which also skips empty rows
  always_comb begin
    row_class = cur_class;
    for (int c = 0; c < CLASS_CNT - 1; c++) begin
      if (ROW_PTRS[int'(row_class) + 1] <= nz_idx) begin
        row_class = row_class + 1'b1;
      end
    end
  end

  assign col = COL_INDICES[step][HIDDEN_IDX_BITS-1:0];
  assign match = NZ_VALS[step] ~^ hidden[col];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_class <= '0;
      scores <= '0;
    end else if (load) begin
      cur_class <= '0;
      scores <= '0;
    end else if (l2_step) begin
      cur_class <= row_class;
      scores.score[row_class] <= scores.score[row_class] + SCORE_BITS'(match);
    end
  end

endmodule

/* hw/argmax_tree.sv */
`timescale 1ns/100ps

module argmax_tree (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           finish,
  input  tnn_pkg::tnn_scores_t           scores,
  output logic [tnn_pkg::CLASS_BITS-1:0] prediction
);

  import tnn_pkg::*;

  logic [CLASS_CNT-1:0][CLASS_BITS-1:0] idx;
  logic [CLASS_CNT-1:0][SCORE_BITS-1:0] val;

  // each level reduces in place with slot k taking the winner of slots 2k and 2k+1
  always_comb begin
    for (int c = 0; c < CLASS_CNT; c++) begin
      idx[c] = CLASS_BITS'(c);
      val[c] = scores.score[c];
    end
    for (int lvl = 0; lvl < CLASS_BITS; lvl++) begin
      for (int k = 0; k < CLASS_CNT / 2; k++) begin
        if (k < (CLASS_CNT >> (lvl + 1))) begin
          if (val[2*k+1] > val[2*k]) begin // a tie keeps the lower index on the left
            idx[k] = idx[2*k+1];
            val[k] = val[2*k+1];
          end else begin
            idx[k] = idx[2*k];
            val[k] = val[2*k];
          end
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      prediction <= '0;
    end else if (finish) begin
      prediction <= idx[0];
    end
  end

endmodule

/* hw/seq_tnn.sv */
`timescale 1ns/100ps

module seq_tnn (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           start,
  input  tnn_pkg::tnn_features_t         features,
  output logic [tnn_pkg::CLASS_BITS-1:0] prediction,
  output logic                           done,
  output logic                           busy
);

  import tnn_pkg::*;

  tnn_phase_t           phase;
  logic [STEP_BITS-1:0] step;
  logic                 last;
  logic                 load;
  logic                 l1_step;
  logic                 l2_step;
  logic                 finish;
  tnn_hidden_t          hidden;
  tnn_scores_t          scores;

  tnn_ctrl ctrl_i (
    .clk(clk), .rst_n(rst_n), .start(start), .last(last), .phase(phase),
    .load(load), .l1_step(l1_step), .l2_step(l2_step), .finish(finish),
    .done(done), .busy(busy)
  );

  tnn_step_counter counter_i (
    .clk(clk), .rst_n(rst_n), .phase(phase), .step(step), .last(last)
  );

  ternary_layer layer1_i (
    .clk(clk), .rst_n(rst_n), .load(load), .l1_step(l1_step),
    .features(features), .step(step), .hidden(hidden)
  );

  xnor_layer layer2_i (
    .clk(clk), .rst_n(rst_n), .load(load), .l2_step(l2_step),
    .step(step), .hidden(hidden), .scores(scores)
  );

  argmax_tree argmax_i (
    .clk(clk), .rst_n(rst_n), .finish(finish), .scores(scores), .prediction(prediction)
  );

endmodule

/* include/tnn_ref_model.svh */
`ifndef TNN_REF_MODEL_SVH
`define TNN_REF_MODEL_SVH

function automatic tnn_pkg::tnn_hidden_t ref_hidden(input tnn_pkg::tnn_features_t f);
  tnn_pkg::tnn_hidden_t h;
  int pos;
  int neg;
  for (int n = 0; n < tnn_pkg::HIDDEN_CNT; n++) begin
    pos = 0;
    neg = 0;
    for (int k = 0; k < tnn_pkg::FEAT_CNT; k++) begin
      if (tnn_pkg::POS_MASK[n][k]) pos = pos + int'(f.feat[k]);
      if (tnn_pkg::NEG_MASK[n][k]) neg = neg + int'(f.feat[k]);
    end
    h[n] = (pos > neg);
  end
  return h;
endfunction

function automatic tnn_pkg::tnn_scores_t ref_scores(input tnn_pkg::tnn_hidden_t h);
  tnn_pkg::tnn_scores_t s;
  int col;
  s = '0;
  for (int c = 0; c < tnn_pkg::CLASS_CNT; c++) begin
    for (int nz = int'(tnn_pkg::ROW_PTRS[c]); nz < int'(tnn_pkg::ROW_PTRS[c+1]); nz++) begin
      col = int'(tnn_pkg::COL_INDICES[nz]);
      if (tnn_pkg::NZ_VALS[nz] == h[col]) s.score[c] = s.score[c] + 1'b1;
    end
  end
  return s;
endfunction

// lowest index wins on a tie
function automatic logic [tnn_pkg::CLASS_BITS-1:0] ref_class(input tnn_pkg::tnn_scores_t s);
  int best;
  best = 0;
  for (int c = 1; c < tnn_pkg::CLASS_CNT; c++) begin
    if (s.score[c] > s.score[best]) best = c;
  end
  return tnn_pkg::CLASS_BITS'(best);
endfunction

function automatic logic [tnn_pkg::CLASS_BITS-1:0] ref_predict(input tnn_pkg::tnn_features_t f);
  return ref_class(ref_scores(ref_hidden(f)));
endfunction

`endif

/* verification/seq_tnn_tb.sv */
`timescale 1ns/100ps

module seq_tnn_tb;

  import tnn_pkg::*;

  `include "tnn_ref_model.svh"

  localparam int CLK_HALF = 10;
  localparam int RESET_CYCLES = 8;
  localparam int IDLE_CHECK_CYCLES = 6;
  localparam int RANDOM_RUNS = 300;
  localparam int DIRECTED_RUNS = FEAT_CNT + 2;
  localparam int LATENCY = HIDDEN_CNT + NONZERO_TOTAL + 1; // accept edge to done
  localparam int RUN_CYCLES = HIDDEN_CNT + NONZERO_TOTAL + 4;
  localparam int WATCHDOG_CYCLES = (RANDOM_RUNS + DIRECTED_RUNS) * RUN_CYCLES
                                   + RESET_CYCLES + IDLE_CHECK_CYCLES + 20;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  start;
  tnn_features_t         features;
  logic [CLASS_BITS-1:0] prediction;
  logic                  done;
  logic                  busy;

  int seed;
  int error_cnt = 0;
  int accepted_cnt = 0;
  int done_cnt = 0;

  always #(CLK_HALF) clk = ~clk;

  seq_tnn dut_i (
    .clk(clk), .rst_n(rst_n), .start(start), .features(features),
    .prediction(prediction), .done(done), .busy(busy)
  );

  // counts every cycle with done high, so a stretched pulse shows up as an extra count
  always @(negedge clk) begin
    if (rst_n && done) begin
      done_cnt = done_cnt + 1;
    end
  end

  task automatic report_mismatch(input string name, input int expected, input int actual);
    error_cnt++;
    $display("[FAIL] t=%0t %s expected=%0d actual=%0d", $time, name, expected, actual);
  endtask

  task automatic report_problem(input string what);
    error_cnt++;
    $display("error at t=%0t: %s", $time, what);
  endtask

  // one full run, with optional start noise while the DUT is busy
  task automatic run_vector(input tnn_features_t vec, input logic inject);
    logic [CLASS_BITS-1:0] expected;
    logic [31:0]           rnd;
    expected = ref_predict(vec);
    @(posedge clk);
    start <= 1'b1;
    features <= vec;
    @(posedge clk); // start is taken at edge 0
    rnd = $random(seed);
    start <= 1'b0;
    features <= tnn_features_t'(rnd[15:0]); // the run must use the captured copy
    accepted_cnt++;
    @(negedge clk);
    if (busy !== 1'b1) begin
      report_mismatch("busy", 1, int'(busy));
    end
    for (int k = 1; k <= LATENCY + 1; k++) begin
      @(posedge clk);
      if (inject && k < LATENCY) begin
        rnd = $random(seed);
        start <= rnd[0] & rnd[1];
        features <= tnn_features_t'(rnd[31:16]);
      end else begin
        start <= 1'b0;
      end
      @(negedge clk);
      if (k < LATENCY) begin
        if (busy !== 1'b1) begin
          report_mismatch("busy", 1, int'(busy));
        end
        if (done !== 1'b0) begin
          report_mismatch("done", 0, int'(done));
        end
      end else if (k == LATENCY) begin
        if (done !== 1'b1) begin
          report_mismatch("done", 1, int'(done));
        end
        if (busy !== 1'b0) begin
          report_mismatch("busy", 0, int'(busy));
        end
        if (prediction !== expected) begin
          report_mismatch("prediction", int'(expected), int'(prediction));
        end
      end else begin
        if (done !== 1'b0) begin
          report_mismatch("done", 0, int'(done));
        end
        if (prediction !== expected) begin // held after the pulse
          report_mismatch("prediction", int'(expected), int'(prediction));
        end
      end
    end
  endtask

  initial begin
    tnn_features_t vec;
    logic [31:0]   rnd;
    seed = 32'hd9ae_7a4f;
    rst_n <= 1'b0;
    start <= 1'b0;
    features <= '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;

    for (int i = 0; i < IDLE_CHECK_CYCLES; i++) begin
      @(negedge clk);
      if (done !== 1'b0) begin
        report_mismatch("done", 0, int'(done));
      end
      if (busy !== 1'b0) begin
        report_mismatch("busy", 0, int'(busy));
      end
      if (prediction !== '0) begin
        report_mismatch("prediction", 0, int'(prediction));
      end
    end

    // zero sums everywhere give an all-zero hidden vector
    run_vector('0, 1'b0);
    run_vector('1, 1'b0);
    for (int f = 0; f < FEAT_CNT; f++) begin
      vec = '0;
      vec.feat[f] = 4'hf;
      run_vector(vec, 1'b0);
    end

    for (int r = 0; r < RANDOM_RUNS; r++) begin
      rnd = $random(seed);
      vec = tnn_features_t'(rnd[15:0]);
      run_vector(vec, rnd[16]);
    end

    @(posedge clk);
    if (done_cnt != accepted_cnt) begin
      report_problem($sformatf("saw %0d done cycles for %0d accepted starts",
                               done_cnt, accepted_cnt));
    end

    $display("runs=%0d done_pulses=%0d errors=%0d", accepted_cnt, done_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * 2 * CLK_HALF);
    $display("watchdog expired after %0d cycles before the tests finished", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* files.f */
+incdir+include
hw/tnn_pkg.sv
hw/tnn_ctrl.sv
hw/tnn_step_counter.sv
hw/ternary_layer.sv
hw/xnor_layer.sv
hw/argmax_tree.sv
hw/seq_tnn.sv
verification/seq_tnn_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f files.f --top-module seq_tnn_tb -o seq_tnn_sim
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

sim_out=$(./obj_dir/seq_tnn_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "Done: no errors"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
